/* icache_pkg.sv */
`default_nettype none

package icache_pkg;

    localparam int ADDR_W     = 32;
    localparam int LINE_WORDS = 4;
    localparam int NUM_LINES  = 16;
    localparam int OFFSET_W   = 2;  // Word in line
    localparam int INDEX_W    = 4;
    localparam int TAG_W      = 24;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
        logic [1:0]          byte_sel;
    } fetch_fields_t;

    // Same fetch address, plain or split into cache fields
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        fetch_fields_t     fields;
    } fetch_addr_u;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } line_tag_t;

    typedef struct packed {
        logic enable;
        logic flush_req;     // One cycle pulse
        logic clear_counts;  // One cycle pulse
    } icache_ctrl_t;

    typedef struct packed {
        logic hit;
        logic miss;
    } icache_event_t;

    // Register map
    localparam logic [ADDR_W-1:0] CSR_CTRL   = 32'h0;
    localparam logic [ADDR_W-1:0] CSR_HITS   = 32'h4;
    localparam logic [ADDR_W-1:0] CSR_MISSES = 32'h8;
    localparam logic [ADDR_W-1:0] CSR_CLEAR  = 32'hc;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

/* icache_core.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_core
    import icache_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          cpu_req_valid,
    input  fetch_addr_u   cpu_req_addr,
    output logic          cpu_req_ready,
    output logic          cpu_rsp_valid,
    output logic [31:0]   cpu_rsp_data,
    output logic          mem_req_valid,
    output logic [31:0]   mem_req_addr,
    input  logic          mem_req_ready,
    input  logic          mem_rsp_valid,
    input  logic [31:0]   mem_rsp_data,
    input  icache_ctrl_t  ctrl,
    output icache_event_t events
);

    typedef enum logic [1:0] {ST_LOOKUP, ST_REFILL, ST_BYPASS, ST_FLUSH} state_t;

    state_t              state;
    line_tag_t           tag_mem [NUM_LINES];
    logic [31:0]         data_mem [NUM_LINES][LINE_WORDS];

    fetch_addr_u         req_addr;
    logic                req_pend;    // Accepted, not yet answered
    logic                flush_pend;
    logic                mem_wait;    // Memory request outstanding
    logic [OFFSET_W-1:0] beat;
    logic                rsp_valid_q;
    logic [31:0]         rsp_data_q;
    logic [1:0]          inflight;

    line_tag_t           cur_tag;
    logic                tag_match;
    logic                lookup_hit;
    logic                lookup_miss;
    logic                to_bypass;
    logic                flush_wait;
    logic                flush_go;
    logic                clear_valid;
    logic                accept;
    logic                last_beat;

    assign cur_tag   = tag_mem[req_addr.fields.index];
    assign tag_match = cur_tag.valid && (cur_tag.tag == req_addr.fields.tag);

    // Lookup runs the cycle after accept
    assign lookup_hit  = (state == ST_LOOKUP) && req_pend && ctrl.enable && tag_match;
    assign lookup_miss = (state == ST_LOOKUP) && req_pend && ctrl.enable && !tag_match;
    assign to_bypass   = (state == ST_LOOKUP) && req_pend && !ctrl.enable;

    assign flush_wait  = flush_pend || ctrl.flush_req;
    assign flush_go    = (state == ST_LOOKUP) && flush_wait && (!req_pend || lookup_hit);
    assign clear_valid = flush_go || (state == ST_FLUSH);

    assign cpu_req_ready = (state == ST_LOOKUP) && !flush_wait && (!req_pend || lookup_hit);
    assign accept        = cpu_req_valid && cpu_req_ready;
    assign last_beat     = (state == ST_REFILL) && mem_rsp_valid &&
                           (beat == OFFSET_W'(LINE_WORDS - 1));

    assign cpu_rsp_valid = lookup_hit || rsp_valid_q;
    assign cpu_rsp_data  = lookup_hit ?
                           data_mem[req_addr.fields.index][req_addr.fields.offset] : rsp_data_q;

    assign events.hit  = lookup_hit;
    assign events.miss = lookup_miss;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state         <= ST_LOOKUP;
            req_pend      <= 1'b0;
            flush_pend    <= 1'b0;
            mem_req_valid <= 1'b0;
            mem_wait      <= 1'b0;
            beat          <= '0;
            rsp_valid_q   <= 1'b0;
        end
        else
        begin
            rsp_valid_q <= 1'b0;
            flush_pend  <= flush_wait && !clear_valid;  // Held over a refill
            if (mem_req_valid && mem_req_ready)
            begin
                mem_req_valid <= 1'b0;
                mem_wait      <= 1'b1;
            end
            if (mem_rsp_valid)
                mem_wait <= 1'b0;

            case (state)
                ST_LOOKUP:
                begin
                    if (lookup_miss)
                    begin
                        state         <= ST_REFILL;
                        beat          <= '0;
                        mem_req_valid <= 1'b1;
                    end
                    else if (to_bypass)
                    begin
                        state         <= ST_BYPASS;
                        mem_req_valid <= 1'b1;
                    end
                    else
                        req_pend <= accept;
                end
                ST_REFILL:
                begin
                    if (last_beat)
                    begin
                        rsp_valid_q <= 1'b1;
                        req_pend    <= 1'b0;
                        state       <= flush_wait ? ST_FLUSH : ST_LOOKUP;
                    end
                    else if (mem_rsp_valid)
                    begin
                        beat          <= beat + 1'b1;
                        mem_req_valid <= 1'b1;  // Next word of the line
                    end
                end
                ST_BYPASS:
                begin
                    if (mem_rsp_valid)
                    begin
                        rsp_valid_q <= 1'b1;
                        req_pend    <= 1'b0;
                        state       <= flush_wait ? ST_FLUSH : ST_LOOKUP;
                    end
                end
                default:
                    state <= ST_LOOKUP;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            req_addr <= cpu_req_addr;
        if (lookup_miss)
            mem_req_addr <= {req_addr.fields.tag, req_addr.fields.index, {OFFSET_W{1'b0}}, 2'b00};
        else if (to_bypass)
            mem_req_addr <= {req_addr.raw[ADDR_W-1:2], 2'b00};
        else if ((state == ST_REFILL) && mem_rsp_valid && !last_beat)
            mem_req_addr <= mem_req_addr + ADDR_W'(4);
    end

    always_ff @(posedge clk)
    begin
        if ((state == ST_REFILL) && mem_rsp_valid)
            data_mem[req_addr.fields.index][beat] <= mem_rsp_data;
        // Requested word may land on any beat
        if (mem_rsp_valid && ((state == ST_BYPASS) ||
            ((state == ST_REFILL) && (beat == req_addr.fields.offset))))
            rsp_data_q <= mem_rsp_data;
    end

    always_ff @(posedge clk)
    begin
        if (rst || clear_valid)
        begin
            for (int i = 0; i < NUM_LINES; i++)
                tag_mem[i].valid <= 1'b0;
        end
        else if (last_beat)
        begin
            tag_mem[req_addr.fields.index].valid <= 1'b1;
            tag_mem[req_addr.fields.index].tag   <= req_addr.fields.tag;
        end
    end

    // Fetches accepted but not answered
    always_ff @(posedge clk)
    begin
        if (rst)
            inflight <= '0;
        else
            inflight <= inflight + 2'(accept) - 2'(cpu_rsp_valid);
    end

    a_mem_req_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr));

    a_rsp_after_req: assert property (@(posedge clk) disable iff (rst)
        cpu_rsp_valid |-> inflight != 2'd0);

    a_mem_rsp_expected: assert property (@(posedge clk) disable iff (rst)
        mem_rsp_valid |-> mem_wait);

endmodule

`default_nettype wire

/* icache_csr.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_csr
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              awvalid,
    output logic              awready,
    input  logic [ADDR_W-1:0] awaddr,
    input  logic              wvalid,
    output logic              wready,
    input  logic [31:0]       wdata,
    input  logic [3:0]        wstrb,
    output logic              bvalid,
    input  logic              bready,
    output logic [1:0]        bresp,
    input  logic              arvalid,
    output logic              arready,
    input  logic [ADDR_W-1:0] araddr,
    output logic              rvalid,
    input  logic              rready,
    output logic [31:0]       rdata,
    output logic [1:0]        rresp,
    output icache_ctrl_t      ctrl,
    input  icache_event_t     events
);

    logic              aw_held;
    logic              w_held;
    logic [ADDR_W-1:0] aw_addr_q;
    logic [31:0]       w_data_q;
    logic [3:0]        w_strb_q;
    logic              aw_take;
    logic              w_take;
    logic              ar_take;
    logic              wr_fire;
    logic [ADDR_W-1:0] wr_addr;
    logic [31:0]       wr_data;
    logic [3:0]        wr_strb;
    logic [31:0]       rd_word;
    logic [31:0]       hits;
    logic [31:0]       misses;

    function automatic logic is_mapped(input logic [ADDR_W-1:0] addr);
        return (addr == CSR_CTRL) || (addr == CSR_HITS) ||
               (addr == CSR_MISSES) || (addr == CSR_CLEAR);
    endfunction

    assign awready = !aw_held && !bvalid;
    assign wready  = !w_held && !bvalid;
    assign arready = !rvalid;

    assign aw_take = awvalid && awready;
    assign w_take  = wvalid && wready;
    assign ar_take = arvalid && arready;

    // Either half may already be parked
    assign wr_addr = aw_held ? aw_addr_q : awaddr;
    assign wr_data = w_held ? w_data_q : wdata;
    assign wr_strb = w_held ? w_strb_q : wstrb;
    assign wr_fire = (aw_held || aw_take) && (w_held || w_take);

    always_comb
    begin
        case (araddr)
            CSR_CTRL:   rd_word = {31'b0, ctrl.enable};  // Flush bit reads 0
            CSR_HITS:   rd_word = hits;
            CSR_MISSES: rd_word = misses;
            default:    rd_word = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            aw_held           <= 1'b0;
            w_held            <= 1'b0;
            bvalid            <= 1'b0;
            bresp             <= RESP_OKAY;
            ctrl.enable       <= 1'b1;
            ctrl.flush_req    <= 1'b0;
            ctrl.clear_counts <= 1'b0;
        end
        else
        begin
            ctrl.flush_req    <= 1'b0;
            ctrl.clear_counts <= 1'b0;
            if (bvalid && bready)
                bvalid <= 1'b0;
            if (wr_fire)
            begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                bvalid  <= 1'b1;
                bresp   <= is_mapped(wr_addr) ? RESP_OKAY : RESP_SLVERR;
                if ((wr_addr == CSR_CTRL) && wr_strb[0])
                begin
                    ctrl.enable    <= wr_data[0];
                    ctrl.flush_req <= wr_data[1];
                end
                if (wr_addr == CSR_CLEAR)
                    ctrl.clear_counts <= 1'b1;  // Any data
            end
            else
            begin
                if (aw_take)
                    aw_held <= 1'b1;
                if (w_take)
                    w_held <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (aw_take)
            aw_addr_q <= awaddr;
        if (w_take)
        begin
            w_data_q <= wdata;
            w_strb_q <= wstrb;
        end
        if (ar_take)
        begin
            rdata <= rd_word;
            rresp <= is_mapped(araddr) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            rvalid <= 1'b0;
        else if (ar_take)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;
    end

    // Saturating event counters
    always_ff @(posedge clk)
    begin
        if (rst || ctrl.clear_counts)
        begin
            hits   <= '0;
            misses <= '0;
        end
        else
        begin
            if (events.hit && (hits != '1))
                hits <= hits + 1'b1;
            if (events.miss && (misses != '1))
                misses <= misses + 1'b1;
        end
    end

    a_b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp));

    a_r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

`default_nettype wire

/* icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_top
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              cpu_req_valid,
    input  fetch_addr_u       cpu_req_addr,
    output logic              cpu_req_ready,
    output logic              cpu_rsp_valid,
    output logic [31:0]       cpu_rsp_data,
    output logic              mem_req_valid,
    output logic [31:0]       mem_req_addr,
    input  logic              mem_req_ready,
    input  logic              mem_rsp_valid,
    input  logic [31:0]       mem_rsp_data,
    input  logic              awvalid,
    output logic              awready,
    input  logic [ADDR_W-1:0] awaddr,
    input  logic              wvalid,
    output logic              wready,
    input  logic [31:0]       wdata,
    input  logic [3:0]        wstrb,
    output logic              bvalid,
    input  logic              bready,
    output logic [1:0]        bresp,
    input  logic              arvalid,
    output logic              arready,
    input  logic [ADDR_W-1:0] araddr,
    output logic              rvalid,
    input  logic              rready,
    output logic [31:0]       rdata,
    output logic [1:0]        rresp
);

    icache_ctrl_t  ctrl;    // CSR to core
    icache_event_t events;  // Core to CSR

    icache_core core_i (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_ready (cpu_req_ready),
        .cpu_rsp_valid (cpu_rsp_valid),
        .cpu_rsp_data  (cpu_rsp_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .ctrl          (ctrl),
        .events        (events)
    );

    icache_csr csr_i (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .ctrl    (ctrl),
        .events  (events)
    );

endmodule

`default_nettype wire

/* tb_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        req_valid,
    input  logic [31:0] req_addr,
    output logic        req_ready,
    output logic        rsp_valid,
    output logic [31:0] rsp_data
);

    // Fixed mix of the address bits
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    initial
    begin
        logic [31:0] addr_q;
        req_ready = 1'b0;
        rsp_valid = 1'b0;
        rsp_data  = '0;
        forever
        begin
            @(posedge clk);
            #1;
            rsp_valid = 1'b0;  // Single beat
            if (!rst && req_valid)
            begin
                repeat ($urandom_range(3, 0))
                begin
                    @(posedge clk);
                    #1;
                end
                addr_q    = req_addr;
                req_ready = 1'b1;
                @(posedge clk);
                #1;
                req_ready = 1'b0;
                repeat ($urandom_range(3, 0))
                begin
                    @(posedge clk);
                    #1;
                end
                rsp_valid = 1'b1;
                rsp_data  = mem_word(addr_q);
            end
        end
    end

endmodule

`default_nettype wire

/* tb_icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_icache_top
    import icache_pkg::*;
();

    localparam int N_RANDOM       = 200;
    localparam int N_BYPASS       = 12;
    localparam int PLANNED_OPS    = N_RANDOM + N_BYPASS + 40;
    localparam int TIMEOUT_CYCLES = 40 * PLANNED_OPS;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic        hit;
        logic [31:0] cyc;  // Negedge count when accept was seen
    } exp_rsp_t;

    logic             clk;
    logic             rst;
    logic             cpu_req_valid;
    fetch_addr_u      cpu_req_addr;
    logic             cpu_req_ready;
    logic             cpu_rsp_valid;
    logic [31:0]      cpu_rsp_data;
    logic             mem_req_valid;
    logic [31:0]      mem_req_addr;
    logic             mem_req_ready;
    logic             mem_rsp_valid;
    logic [31:0]      mem_rsp_data;
    logic             awvalid;
    logic             awready;
    logic [31:0]      awaddr;
    logic             wvalid;
    logic             wready;
    logic [31:0]      wdata;
    logic [3:0]       wstrb;
    logic             bvalid;
    logic             bready;
    logic [1:0]       bresp;
    logic             arvalid;
    logic             arready;
    logic [31:0]      araddr;
    logic             rvalid;
    logic             rready;
    logic [31:0]      rdata;
    logic [1:0]       rresp;

    exp_rsp_t         exp_q[$];
    logic             model_valid [NUM_LINES];
    logic [TAG_W-1:0] model_tag [NUM_LINES];
    logic             model_enable;
    logic [31:0]      model_hits;
    logic [31:0]      model_misses;
    logic [31:0]      cycle = '0;
    int               errors = 0;

    icache_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_ready (cpu_req_ready),
        .cpu_rsp_valid (cpu_rsp_valid),
        .cpu_rsp_data  (cpu_rsp_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .awvalid       (awvalid),
        .awready       (awready),
        .awaddr        (awaddr),
        .wvalid        (wvalid),
        .wready        (wready),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .bvalid        (bvalid),
        .bready        (bready),
        .bresp         (bresp),
        .arvalid       (arvalid),
        .arready       (arready),
        .araddr        (araddr),
        .rvalid        (rvalid),
        .rready        (rready),
        .rdata         (rdata),
        .rresp         (rresp)
    );

    tb_mem_model mem_i (
        .clk       (clk),
        .rst       (rst),
        .req_valid (mem_req_valid),
        .req_addr  (mem_req_addr),
        .req_ready (mem_req_ready),
        .rsp_valid (mem_rsp_valid),
        .rsp_data  (mem_rsp_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle <= cycle + 32'd1;
        if (cycle >= 32'(TIMEOUT_CYCLES))
        begin
            $display("Timeout after %0d cycles, the run did not finish", cycle);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [TAG_W-1:0] pick_tag(input int unsigned sel);
        case (sel)
            0:       return 24'h000123;
            1:       return 24'h0abcde;
            2:       return 24'h400010;
            default: return 24'hfff001;
        endcase
    endfunction

    function automatic fetch_addr_u make_addr(input logic [TAG_W-1:0] tag,
                                              input logic [INDEX_W-1:0] index,
                                              input logic [OFFSET_W-1:0] offset);
        fetch_addr_u a;
        a.fields.tag      = tag;
        a.fields.index    = index;
        a.fields.offset   = offset;
        a.fields.byte_sel = 2'b00;
        return a;
    endfunction

    // Small tag pool so lines get reused and evicted
    function automatic fetch_addr_u random_addr();
        return make_addr(pick_tag($urandom_range(3, 0)),
                         INDEX_W'($urandom_range(NUM_LINES - 1, 0)),
                         OFFSET_W'($urandom_range(LINE_WORDS - 1, 0)));
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_ctrl_rd(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Response checker in request order
    always @(negedge clk)
    begin : rsp_monitor
        exp_rsp_t e;
        if (!rst && cpu_rsp_valid)
        begin
            if (exp_q.size() == 0)
            begin
                $display("Fetch response arrived with no fetch outstanding");
                errors++;
            end
            else
            begin
                e = exp_q.pop_front();
                check_word("cpu_rsp_data", cpu_rsp_data, e.data);
                if (e.hit && (cycle != e.cyc + 32'd1))
                begin
                    $display("Hit at %h answered %0d cycles after accept instead of 1",
                             e.addr, cycle - e.cyc);
                    errors++;
                end
            end
        end
    end

    // Model decides hit or miss at accept in lookup order
    task automatic fetch(input fetch_addr_u a);
        exp_rsp_t e;
        cpu_req_valid = 1'b1;
        cpu_req_addr  = a;
        @(negedge clk);
        while (!cpu_req_ready)
            @(negedge clk);
        e.addr = a.raw;
        e.data = expected_word({a.raw[31:2], 2'b00});
        e.hit  = 1'b0;
        e.cyc  = cycle;
        if (model_enable)
        begin
            if (model_valid[a.fields.index] && (model_tag[a.fields.index] == a.fields.tag))
            begin
                e.hit      = 1'b1;
                model_hits = model_hits + 32'd1;
            end
            else
            begin
                model_misses                = model_misses + 32'd1;
                model_valid[a.fields.index] = 1'b1;
                model_tag[a.fields.index]   = a.fields.tag;
            end
        end
        exp_q.push_back(e);
        @(posedge clk);
        #1;
        cpu_req_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        logic aw_hs;
        logic w_hs;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = 4'hf;
        while (awvalid || wvalid)
        begin
            @(negedge clk);
            aw_hs = awvalid && awready;
            w_hs  = wvalid && wready;
            @(posedge clk);
            #1;
            if (aw_hs)
                awvalid = 1'b0;
            if (w_hs)
                wvalid = 1'b0;
        end
        bready = 1'b1;
        @(negedge clk);
        while (!bvalid)
            @(negedge clk);
        resp = bresp;
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        arvalid = 1'b1;
        araddr  = addr;
        @(negedge clk);
        while (!arready)
            @(negedge clk);
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        rready  = 1'b1;
        @(negedge clk);
        while (!rvalid)
            @(negedge clk);
        data = rdata;
        resp = rresp;
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic write_csr(input logic [31:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp);
        logic [1:0] resp;
        axi_write(addr, data, resp);
        check_resp($sformatf("bresp@%h", addr), resp, exp_resp);
    endtask

    task automatic read_csr(input logic [31:0] addr, input logic [31:0] exp_data,
                            input logic [1:0] exp_resp);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(addr, data, resp);
        check_resp($sformatf("rresp@%h", addr), resp, exp_resp);
        check_ctrl_rd($sformatf("rdata@%h", addr), data, exp_data);
    endtask

    initial
    begin
        fetch_addr_u a_addr;
        fetch_addr_u b_addr;
        void'($urandom(32'hc0bc));
        rst           = 1'b1;
        cpu_req_valid = 1'b0;
        cpu_req_addr  = '0;
        awvalid       = 1'b0;
        awaddr        = '0;
        wvalid        = 1'b0;
        wdata         = '0;
        wstrb         = '0;
        bready        = 1'b0;
        arvalid       = 1'b0;
        araddr        = '0;
        rready        = 1'b0;
        model_enable  = 1'b1;
        model_hits    = '0;
        model_misses  = '0;
        for (int i = 0; i < NUM_LINES; i++)
            model_valid[i] = 1'b0;
        a_addr = make_addr(24'h000123, 4'd5, 2'd2);
        b_addr = make_addr(24'h0abcde, 4'd9, 2'd1);
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        read_csr(CSR_CTRL, 32'd1, RESP_OKAY);
        read_csr(CSR_HITS, 32'd0, RESP_OKAY);
        read_csr(CSR_MISSES, 32'd0, RESP_OKAY);

        for (int i = 0; i < N_RANDOM; i++)
        begin
            fetch(random_addr());
            if ($urandom_range(3, 0) == 0)
            begin
                repeat ($urandom_range(2, 1))
                begin
                    @(posedge clk);
                    #1;
                end
            end
        end
        drain();
        read_csr(CSR_HITS, model_hits, RESP_OKAY);
        read_csr(CSR_MISSES, model_misses, RESP_OKAY);

        // Back to back hits on one line
        fetch(a_addr);
        drain();
        for (int w = 0; w < LINE_WORDS; w++)
            fetch(make_addr(a_addr.fields.tag, a_addr.fields.index, OFFSET_W'(w)));
        fetch(b_addr);
        drain();

        write_csr(CSR_CLEAR, 32'h0, RESP_OKAY);
        model_hits   = '0;
        model_misses = '0;
        read_csr(CSR_HITS, 32'd0, RESP_OKAY);
        read_csr(CSR_MISSES, 32'd0, RESP_OKAY);

        // Bypass fills nothing and counts nothing
        write_csr(CSR_CTRL, 32'h0, RESP_OKAY);
        model_enable = 1'b0;
        read_csr(CSR_CTRL, 32'd0, RESP_OKAY);
        fetch(a_addr);
        fetch(make_addr(24'hfff001, a_addr.fields.index, 2'd0));  // Same line, other tag
        for (int i = 0; i < N_BYPASS; i++)
            fetch(random_addr());
        drain();
        read_csr(CSR_HITS, 32'd0, RESP_OKAY);
        read_csr(CSR_MISSES, 32'd0, RESP_OKAY);

        write_csr(CSR_CTRL, 32'h1, RESP_OKAY);
        model_enable = 1'b1;
        fetch(a_addr);
        drain();
        read_csr(CSR_HITS, 32'd1, RESP_OKAY);
        read_csr(CSR_MISSES, 32'd0, RESP_OKAY);

        write_csr(CSR_CLEAR, 32'h5, RESP_OKAY);
        model_hits   = '0;
        model_misses = '0;
        write_csr(CSR_CTRL, 32'h3, RESP_OKAY);  // Enable plus flush
        for (int i = 0; i < NUM_LINES; i++)
            model_valid[i] = 1'b0;
        read_csr(CSR_CTRL, 32'd1, RESP_OKAY);
        fetch(a_addr);
        fetch(b_addr);
        drain();
        read_csr(CSR_HITS, 32'd0, RESP_OKAY);
        read_csr(CSR_MISSES, 32'd2, RESP_OKAY);

        fetch(a_addr);
        drain();
        write_csr(32'h10, 32'h1234_5678, RESP_SLVERR);
        read_csr(32'h10, 32'd0, RESP_SLVERR);
        write_csr(CSR_HITS, 32'hdead_beef, RESP_OKAY);
        read_csr(CSR_HITS, model_hits, RESP_OKAY);
        read_csr(CSR_MISSES, model_misses, RESP_OKAY);

        repeat (2) @(posedge clk);
        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
icache_pkg.sv
icache_core.sv
icache_csr.sv
icache_top.sv
tb_mem_model.sv
tb_icache_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_icache_top
RTL_TOP   ?= icache_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RTL_SRCS  ?= icache_pkg.sv icache_core.sv icache_csr.sv icache_top.sv

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "No pass line found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
